// ==== rtl/obi_pkg.sv ====
package obi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Address and data widths of the shared OBI bus
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // One byte enable per data byte
  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  // Address/attribute checksum driven with every request
  localparam int unsigned ACHK_WIDTH = 12;

  // Response checksum returned by the memory with every rvalid
  localparam int unsigned RCHK_WIDTH = 5;

  //////////////////////////////////////////////////////////////////////
  // Arbiter source queue
  //////////////////////////////////////////////////////////////////////

  // Number of transactions that may be in flight on the shared bus
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Occupancy counter must be able to hold MAX_OUTSTANDING itself
  localparam int unsigned SRC_CNT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  // Index into the queue entries
  localparam int unsigned SRC_PTR_WIDTH = $clog2(MAX_OUTSTANDING);

  //////////////////////////////////////////////////////////////////////
  // Attribute encodings
  //////////////////////////////////////////////////////////////////////

  // Bit of memtype that marks an access as bufferable
  localparam int unsigned MEMTYPE_BUFFERABLE = 0;

  // Owner of a granted transaction, used to steer its response back
  typedef enum logic [0:0] {
    SRC_INSTR = 1'b0,
    SRC_DATA  = 1'b1
  } obi_src_e;

  //////////////////////////////////////////////////////////////////////
  // Request and response payloads
  //////////////////////////////////////////////////////////////////////

  // Everything that travels with req, held stable until gnt
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
    logic [1:0]            memtype;
    logic [2:0]            prot;
    logic                  dbg;
  } obi_req_t;

  // Everything that travels with rvalid
  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } obi_rsp_t;

endpackage

// ==== rtl/obi_arbiter.sv ====
`timescale 1ns/1ps

module obi_arbiter (
  input  logic              clk,
  input  logic              rst_ni,

  // Instruction fetch requester
  input  logic              instr_req_i,
  input  obi_pkg::obi_req_t instr_req_data_i,
  output logic              instr_gnt_o,
  output logic              instr_rvalid_o,

  // Load/store requester
  input  logic              data_req_i,
  input  obi_pkg::obi_req_t data_req_data_i,
  output logic              data_gnt_o,
  output logic              data_rvalid_o,

  // Shared external bus
  output logic              bus_req_o,
  output obi_pkg::obi_req_t bus_req_data_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i
);

  // Source of each outstanding transaction, oldest in entry 0
  obi_pkg::obi_src_e [obi_pkg::MAX_OUTSTANDING-1:0] src_q;
  obi_pkg::obi_src_e [obi_pkg::MAX_OUTSTANDING-1:0] src_n;
  logic [obi_pkg::SRC_CNT_WIDTH-1:0]                src_cnt_q;
  logic [obi_pkg::SRC_CNT_WIDTH-1:0]                src_cnt_n;

  obi_pkg::obi_src_e src_sel;
  logic              queue_full;
  logic              bus_grant;
  logic              rsp_valid;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Data port has fixed priority, a waiting fetch just holds its request
  assign src_sel = data_req_i ? obi_pkg::SRC_DATA : obi_pkg::SRC_INSTR;

  // No new request goes out while every queue slot is taken
  assign queue_full = (src_cnt_q == obi_pkg::SRC_CNT_WIDTH'(obi_pkg::MAX_OUTSTANDING));

  assign bus_req_o = (instr_req_i || data_req_i) && !queue_full;

  always_comb begin
    bus_req_data_o = (src_sel == obi_pkg::SRC_DATA) ? data_req_data_i : instr_req_data_i;
    // Fetches and loads are never bufferable, only stores keep the bit
    if ((src_sel == obi_pkg::SRC_INSTR) || !data_req_data_i.we) begin
      bus_req_data_o.memtype[obi_pkg::MEMTYPE_BUFFERABLE] = 1'b0;
    end
  end

  // Address phase completes when the memory accepts the request
  assign bus_grant = bus_req_o && bus_gnt_i;

  assign data_gnt_o  = bus_grant && (src_sel == obi_pkg::SRC_DATA);
  assign instr_gnt_o = bus_grant && (src_sel == obi_pkg::SRC_INSTR);

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  // A response always belongs to the oldest transaction
  assign rsp_valid = bus_rvalid_i && (src_cnt_q != '0);

  assign data_rvalid_o  = rsp_valid && (src_q[0] == obi_pkg::SRC_DATA);
  assign instr_rvalid_o = rsp_valid && (src_q[0] == obi_pkg::SRC_INSTR);

  // Pop first, then append the new source behind what is left
  always_comb begin
    src_n     = src_q;
    src_cnt_n = src_cnt_q;
    if (rsp_valid) begin
      for (int i = 0; i < obi_pkg::MAX_OUTSTANDING - 1; i++) begin
        src_n[i] = src_q[i+1];
      end
      src_cnt_n = src_cnt_n - 1'b1;
    end
    if (bus_grant) begin
      // Grant is blocked when full, so the slot index stays in range
      src_n[src_cnt_n[obi_pkg::SRC_PTR_WIDTH-1:0]] = src_sel;
      src_cnt_n = src_cnt_n + 1'b1;
    end
  end

  // Occupancy is the only control state of the queue
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      src_cnt_q <= '0;
    end else begin
      src_cnt_q <= src_cnt_n;
    end
  end

  // Entries beyond the count are don't care
  always_ff @(posedge clk) begin
    src_q <= src_n;
  end

endmodule

// ==== rtl/obi_req_integrity.sv ====
`timescale 1ns/1ps

module obi_req_integrity (
  input  logic                           bus_req_i,
  input  obi_pkg::obi_req_t              bus_req_data_i,
  output logic                           reqpar_o,
  output logic [obi_pkg::ACHK_WIDTH-1:0] achk_o
);

  //////////////////////////////////////////////////////////////////////
  // Request parity
  //////////////////////////////////////////////////////////////////////

  // The strobe is protected by its own inverted copy
  assign reqpar_o = ~bus_req_i;

  //////////////////////////////////////////////////////////////////////
  // Address/attribute checksum
  //////////////////////////////////////////////////////////////////////

  // Layout, LSB first
  // 3..0 are even parity of the address bytes
  // 4 is odd parity of prot and memtype
  // 5 is odd parity of be and we
  // 6 is odd parity of dbg
  // 7 is reserved and reads as zero
  // 11..8 are even parity of the write data bytes
  always_comb begin
    achk_o = '0;

    // Address bytes, byte 0 lands in bit 0
    for (int b = 0; b < 4; b++) begin
      achk_o[b] = ^bus_req_data_i.addr[8*b +: 8];
    end

    // Attribute groups use odd parity so an all-zero bus is caught
    achk_o[4] = ~^{bus_req_data_i.prot, bus_req_data_i.memtype};
    achk_o[5] = ~^{bus_req_data_i.be, bus_req_data_i.we};
    achk_o[6] = ~^bus_req_data_i.dbg;

    // Write data bytes, fetches carry zero data so these stay low
    for (int b = 0; b < 4; b++) begin
      achk_o[8+b] = ^bus_req_data_i.wdata[8*b +: 8];
    end
  end

endmodule

// ==== rtl/obi_rsp_integrity.sv ====
`timescale 1ns/1ps

module obi_rsp_integrity (
  input  logic                           clk,
  input  logic                           rst_ni,

  // Handshake strobes with their inverted companions
  input  logic                           gnt_i,
  input  logic                           gntpar_i,
  input  logic                           rvalid_i,
  input  logic                           rvalidpar_i,

  // Response payload and its checksum
  input  obi_pkg::obi_rsp_t              rsp_i,
  input  logic [obi_pkg::RCHK_WIDTH-1:0] rchk_i,

  // Sticky integrity alert
  output logic                           integrity_err_o
);

  logic [obi_pkg::RCHK_WIDTH-1:0] rchk_exp;
  logic                           gnt_err;
  logic                           rvalid_err;
  logic                           rchk_err;
  logic                           alert_q;

  //////////////////////////////////////////////////////////////////////
  // Strobe parity
  //////////////////////////////////////////////////////////////////////

  // A strobe and its companion must always differ, checked every cycle
  assign gnt_err    = (gnt_i == gntpar_i);
  assign rvalid_err = (rvalid_i == rvalidpar_i);

  //////////////////////////////////////////////////////////////////////
  // Response checksum
  //////////////////////////////////////////////////////////////////////

  // Even parity per read data byte plus one bit for err
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      rchk_exp[b] = ^rsp_i.rdata[8*b +: 8];
    end
    rchk_exp[4] = ^rsp_i.err;
  end

  // Payload is only meaningful while rvalid is high
  assign rchk_err = rvalid_i && (rchk_i != rchk_exp);

  // Once raised the alert holds until the next reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (gnt_err || rvalid_err || rchk_err) begin
      alert_q <= 1'b1;
    end
  end

  assign integrity_err_o = alert_q;

endmodule

// ==== rtl/obi_mux_top.sv ====
`timescale 1ns/1ps

module obi_mux_top (
  input  logic                           clk,
  input  logic                           rst_ni,

  // Instruction fetch port
  input  logic                           instr_req_i,
  input  obi_pkg::obi_req_t              instr_req_data_i,
  output logic                           instr_gnt_o,
  output logic                           instr_rvalid_o,
  output obi_pkg::obi_rsp_t              instr_rsp_o,

  // Load/store port
  input  logic                           data_req_i,
  input  obi_pkg::obi_req_t              data_req_data_i,
  output logic                           data_gnt_o,
  output logic                           data_rvalid_o,
  output obi_pkg::obi_rsp_t              data_rsp_o,

  // External bus, address phase
  output logic                           req_o,
  output logic                           reqpar_o,
  output obi_pkg::obi_req_t              req_data_o,
  output logic [obi_pkg::ACHK_WIDTH-1:0] achk_o,

  // External bus, response phase
  input  logic                           gnt_i,
  input  logic                           gntpar_i,
  input  logic                           rvalid_i,
  input  logic                           rvalidpar_i,
  input  obi_pkg::obi_rsp_t              rsp_i,
  input  logic [obi_pkg::RCHK_WIDTH-1:0] rchk_i,

  // Sticky alert for any bad parity or checksum
  output logic                           integrity_err_o
);

  // Picks a port, fixes memtype and tracks who owns each response
  obi_arbiter i_arbiter (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .instr_req_i      (instr_req_i),
    .instr_req_data_i (instr_req_data_i),
    .instr_gnt_o      (instr_gnt_o),
    .instr_rvalid_o   (instr_rvalid_o),
    .data_req_i       (data_req_i),
    .data_req_data_i  (data_req_data_i),
    .data_gnt_o       (data_gnt_o),
    .data_rvalid_o    (data_rvalid_o),
    .bus_req_o        (req_o),
    .bus_req_data_o   (req_data_o),
    .bus_gnt_i        (gnt_i),
    .bus_rvalid_i     (rvalid_i)
  );

  // Protection bits follow the request that actually goes out
  obi_req_integrity i_req_integrity (
    .bus_req_i      (req_o),
    .bus_req_data_i (req_data_o),
    .reqpar_o       (reqpar_o),
    .achk_o         (achk_o)
  );

  obi_rsp_integrity i_rsp_integrity (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .gnt_i           (gnt_i),
    .gntpar_i        (gntpar_i),
    .rvalid_i        (rvalid_i),
    .rvalidpar_i     (rvalidpar_i),
    .rsp_i           (rsp_i),
    .rchk_i          (rchk_i),
    .integrity_err_o (integrity_err_o)
  );

  // Response payload is shared, the rvalid strobes pick the owner
  assign instr_rsp_o = rsp_i;
  assign data_rsp_o  = rsp_i;

endmodule

// ==== bench/tb_obi_mux_top.sv ====
`timescale 1ns/1ps

module tb_obi_mux_top;

  localparam int unsigned N_FETCH = 16;
  localparam int unsigned N_WR    = 12;
  localparam int unsigned N_RAND  = 40;
  localparam int unsigned N_TOTAL = N_FETCH + 2 * N_WR + 2 * N_RAND + 1;

  logic                           clk;
  logic                           rst_ni;
  logic                           instr_req_i, instr_gnt_o, instr_rvalid_o;
  logic                           data_req_i, data_gnt_o, data_rvalid_o;
  obi_pkg::obi_req_t              instr_req_data_i, data_req_data_i, req_data_o;
  obi_pkg::obi_rsp_t              instr_rsp_o, data_rsp_o, rsp_i;
  logic                           req_o, reqpar_o, gnt_i, gntpar_i;
  logic                           rvalid_i, rvalidpar_i, integrity_err_o;
  logic [obi_pkg::ACHK_WIDTH-1:0] achk_o;
  logic [obi_pkg::RCHK_WIDTH-1:0] rchk_i;

  // Memory array, the copy the data port expects, and one LFSR per user
  logic [31:0]       mem [256];
  logic [31:0]       shadow [256];
  logic [31:0]       mem_lfsr, instr_lfsr, data_lfsr;
  // Owner of each granted transaction and the responses each port expects
  obi_pkg::obi_src_e src_q[$];
  obi_pkg::obi_rsp_t instr_exp_q[$], data_exp_q[$], mem_rsp_q[$];
  int unsigned       mem_due_q[$];
  int unsigned       cycle, last_due, gnt_wait, outstanding;
  logic              alert_exp, corrupt_next;
  string             test_name;

  obi_mux_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference functions
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b     = state[0];
      state = b ? ((state >> 1) ^ 32'ha300_0000) : (state >> 1);
      v     = {v[30:0], b};
    end
    return v;
  endfunction

  // Preload pattern, every byte is a different function of the word index
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {~idx, idx ^ 8'h5a, idx + 8'h3c, idx};
  endfunction

  function automatic logic [obi_pkg::ACHK_WIDTH-1:0] ref_achk(input obi_pkg::obi_req_t r);
    logic [obi_pkg::ACHK_WIDTH-1:0] a;
    a = '0;
    for (int b = 0; b < 4; b++) begin
      a[b]   = ^r.addr[8*b +: 8];
      a[8+b] = ^r.wdata[8*b +: 8];
    end
    a[4] = ~^{r.prot, r.memtype};
    a[5] = ~^{r.be, r.we};
    a[6] = ~r.dbg;
    return a;
  endfunction

  function automatic logic [obi_pkg::RCHK_WIDTH-1:0] ref_rchk(input obi_pkg::obi_rsp_t r);
    logic [obi_pkg::RCHK_WIDTH-1:0] c;
    for (int b = 0; b < 4; b++) begin
      c[b] = ^r.rdata[8*b +: 8];
    end
    c[4] = r.err;
    return c;
  endfunction

  // Fetches and loads must leave the bus non-bufferable
  function automatic logic [1:0] ref_memtype(input obi_pkg::obi_req_t r, input logic fetch);
    logic [1:0] m;
    m = r.memtype;
    if (fetch || !r.we) begin
      m[obi_pkg::MEMTYPE_BUFFERABLE] = 1'b0;
    end
    return m;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      stop_with_failure($sformatf("Mismatch %s %s expected %0h actual %0h",
                                  test_name, name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Requester tasks, entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic issue_fetch(input logic [7:0] idx);
    obi_pkg::obi_req_t r;
    obi_pkg::obi_rsp_t e;
    r         = '0;
    r.addr    = (rand_bits(instr_lfsr, 22) << 10) | (32'(idx) << 2);
    r.be      = '1;
    r.memtype = 2'(rand_bits(instr_lfsr, 2));
    r.prot    = 3'(rand_bits(instr_lfsr, 3));
    r.dbg     = 1'(rand_bits(instr_lfsr, 1));
    e.rdata   = fill_word(idx);
    e.err     = 1'b0;
    instr_exp_q.push_back(e);
    instr_req_data_i = r;
    instr_req_i      = 1'b1;
    @(posedge clk);
    while (!instr_gnt_o)
      @(posedge clk);
    @(negedge clk);
    instr_req_i = 1'b0;
  endtask

  task automatic issue_data(input logic we, input logic [7:0] idx);
    obi_pkg::obi_req_t r;
    obi_pkg::obi_rsp_t e;
    r         = '0;
    r.addr    = (rand_bits(data_lfsr, 22) << 10) | (32'(idx) << 2);
    r.we      = we;
    r.be      = we ? 4'(rand_bits(data_lfsr, 4)) : 4'hf;
    r.wdata   = we ? rand_bits(data_lfsr, 32) : 32'h0;
    r.memtype = 2'(rand_bits(data_lfsr, 2));
    r.prot    = 3'(rand_bits(data_lfsr, 3));
    r.dbg     = 1'(rand_bits(data_lfsr, 1));
    // Writes answer with zero data, reads see every earlier write of this port
    e.rdata   = we ? 32'h0 : shadow[idx];
    e.err     = 1'b0;
    for (int b = 0; b < 4; b++) begin
      if (we && r.be[b]) begin
        shadow[idx][8*b +: 8] = r.wdata[8*b +: 8];
      end
    end
    data_exp_q.push_back(e);
    data_req_data_i = r;
    data_req_i      = 1'b1;
    @(posedge clk);
    while (!data_gnt_o)
      @(posedge clk);
    @(negedge clk);
    data_req_i = 1'b0;
  endtask

  task automatic drain();
    while (outstanding != 0)
      @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  // Samples the bus on the rising edge, drives it on the falling edge
  initial begin : memory_model
    logic [7:0]        idx;
    obi_pkg::obi_rsp_t r;
    int unsigned       due;
    for (int i = 0; i < 256; i++) begin
      mem[i]    = fill_word(8'(i));
      shadow[i] = fill_word(8'(i));
    end
    mem_lfsr     = 32'd69565;
    cycle        = 0;
    last_due     = 0;
    gnt_wait     = 0;
    corrupt_next = 1'b0;
    gnt_i        = 1'b1;
    gntpar_i     = 1'b0;
    rvalid_i     = 1'b0;
    rvalidpar_i  = 1'b1;
    rsp_i        = '0;
    rchk_i       = '0;
    forever begin
      @(posedge clk);
      cycle++;
      if (gnt_wait != 0) begin
        gnt_wait--;
      end
      if (rst_ni && req_o && gnt_i) begin
        idx = req_data_o.addr[9:2];
        r   = '0;
        for (int b = 0; b < 4; b++) begin
          if (req_data_o.we && req_data_o.be[b]) begin
            mem[idx][8*b +: 8] = req_data_o.wdata[8*b +: 8];
          end
        end
        if (!req_data_o.we) begin
          r.rdata = mem[idx];
        end
        // Responses stay in order, each one 1 to 3 cycles after its grant
        due      = cycle + 1 + rand_bits(mem_lfsr, 2) % 3;
        last_due = (due > last_due) ? due : last_due + 1;
        mem_rsp_q.push_back(r);
        mem_due_q.push_back(last_due);
        gnt_wait = rand_bits(mem_lfsr, 2) % 3;
      end
      @(negedge clk);
      gnt_i    = (gnt_wait == 0);
      gntpar_i = ~gnt_i;
      rvalid_i = 1'b0;
      rsp_i    = '0;
      if (mem_due_q.size() != 0 && cycle >= mem_due_q[0]) begin
        void'(mem_due_q.pop_front());
        rvalid_i = 1'b1;
        rsp_i    = mem_rsp_q.pop_front();
      end
      rvalidpar_i = ~rvalid_i;
      rchk_i      = ref_rchk(rsp_i);
      if (rvalid_i && corrupt_next) begin
        rchk_i[0]    = ~rchk_i[0];
        corrupt_next = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : compare
    logic              exp_req;
    obi_pkg::obi_req_t exp_bus;
    obi_pkg::obi_src_e src;
    obi_pkg::obi_rsp_t exp_rsp;
    if (rst_ni) begin
      // Data port wins, and nothing goes out with two transactions in flight
      exp_req = (instr_req_i || data_req_i) && (outstanding < obi_pkg::MAX_OUTSTANDING);
      check_value("req_o", exp_req, req_o);
      check_value("reqpar_o", !exp_req, reqpar_o);
      check_value("data_gnt_o", exp_req && gnt_i && data_req_i, data_gnt_o);
      check_value("instr_gnt_o", exp_req && gnt_i && !data_req_i, instr_gnt_o);
      if (exp_req) begin
        exp_bus         = data_req_i ? data_req_data_i : instr_req_data_i;
        exp_bus.memtype = ref_memtype(exp_bus, !data_req_i);
        check_value("req_data_o", exp_bus, req_data_o);
        check_value("achk_o", ref_achk(exp_bus), achk_o);
      end
      // Alert shows what was wrong on the bus one edge earlier
      check_value("integrity_err_o", alert_exp, integrity_err_o);
      if ((gnt_i == gntpar_i) || (rvalid_i == rvalidpar_i) ||
          (rvalid_i && (rchk_i != ref_rchk(rsp_i)))) begin
        alert_exp = 1'b1;
      end
      if (!rvalid_i) begin
        check_value("instr_rvalid_o", 1'b0, instr_rvalid_o);
        check_value("data_rvalid_o", 1'b0, data_rvalid_o);
      end else if (src_q.size() == 0) begin
        stop_with_failure("Memory returned a response with no transaction outstanding");
      end else begin
        src = src_q.pop_front();
        check_value("instr_rvalid_o", src == obi_pkg::SRC_INSTR, instr_rvalid_o);
        check_value("data_rvalid_o", src == obi_pkg::SRC_DATA, data_rvalid_o);
        if (src == obi_pkg::SRC_INSTR) begin
          exp_rsp = instr_exp_q.pop_front();
          check_value("instr_rsp_o", exp_rsp, instr_rsp_o);
        end else begin
          exp_rsp = data_exp_q.pop_front();
          check_value("data_rsp_o", exp_rsp, data_rsp_o);
        end
        outstanding--;
      end
      if (exp_req && gnt_i) begin
        src_q.push_back(data_req_i ? obi_pkg::SRC_DATA : obi_pkg::SRC_INSTR);
        outstanding++;
      end
    end
  end

  initial begin : watchdog
    repeat (10 + 60 * N_TOTAL) @(posedge clk);
    stop_with_failure("Watchdog expired before all transactions completed");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    rst_ni           = 1'b0;
    instr_req_i      = 1'b0;
    data_req_i       = 1'b0;
    instr_req_data_i = '0;
    data_req_data_i  = '0;
    instr_lfsr       = 32'd69565;
    data_lfsr        = 32'd69565;
    outstanding      = 0;
    alert_exp        = 1'b0;
    test_name        = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;

    test_name = "fetch";
    for (int i = 0; i < N_FETCH; i++)
      issue_fetch(8'(i * 37 + 5));
    drain();

    test_name = "write_read";
    for (int i = 0; i < N_WR; i++)
      issue_data(1'b1, 8'(i * 5));
    for (int i = 0; i < N_WR; i++)
      issue_data(1'b0, 8'(i * 5));
    drain();

    // Fetches stay in the upper half and data in the lower half
    test_name = "random";
    fork
      for (int i = 0; i < N_RAND; i++) begin
        repeat (rand_bits(instr_lfsr, 2)) @(negedge clk);
        issue_fetch(8'(128 + rand_bits(instr_lfsr, 7)));
      end
      for (int i = 0; i < N_RAND; i++) begin
        repeat (rand_bits(data_lfsr, 1)) @(negedge clk);
        issue_data(1'(rand_bits(data_lfsr, 1)), 8'(rand_bits(data_lfsr, 7)));
      end
    join
    drain();

    test_name = "integrity";
    check_value("alert before corruption", 1'b0, integrity_err_o);
    corrupt_next = 1'b1;
    issue_fetch(8'd200);
    drain();
    repeat (4) @(negedge clk);
    check_value("alert after corruption", 1'b1, integrity_err_o);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/obi_pkg.sv
rtl/obi_arbiter.sv
rtl/obi_req_integrity.sv
rtl/obi_rsp_integrity.sv
rtl/obi_mux_top.sv
bench/tb_obi_mux_top.sv

// ==== Bender.yml ====
package:
  name: obi_mux

sources:
  - rtl/obi_pkg.sv
  - rtl/obi_arbiter.sv
  - rtl/obi_req_integrity.sv
  - rtl/obi_rsp_integrity.sv
  - rtl/obi_mux_top.sv
  - target: test
    files:
      - bench/tb_obi_mux_top.sv
